/* Makefile */
# Verilator build and run for the body frame rate controller

VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = tb_body_frame_controller
FILELIST = sim.f
OBJ_DIR = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run fails unless the log holds the pass line
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/rate_input.txt */
// yaw_tgt roll_tgt pitch_tgt yaw_rot roll_rot pitch_rot roll_aerr pitch_aerr ignore
// then expected yaw_out roll_out pitch_out, all signed 12.4 in 16-bit hex
// Proportional steps with the sign inversion and angle errors
00A0 0000 0000 0000 0000 0000 0000 0000 0 0154 0000 0000
0000 0000 0000 00A0 0050 0000 0000 0000 0 0118 FEFC 0000
0000 0000 0000 0000 0000 0030 0050 0000 0 FFD8 0140 009C
FFE0 0030 0020 0000 FFE0 0000 0000 0010 0 FFE4 00B4 0078
// Same error repeated, integral builds up
FFE0 0030 0020 0000 FFE0 0000 0000 0010 0 FFF0 00C8 0084
FFE0 0030 0020 0000 FFE0 0000 0000 0010 0 FFEC 00DC 0090
FFE0 0030 0020 0000 FFE0 0000 0000 0010 0 FFE8 00F0 009C
// Error changes, derivative term and rounding toward minus infinity
0000 0000 0000 0040 0000 FFF0 FFB0 0000 0 00B0 FEFC FFD8
0007 FFFB 0000 0000 0000 0003 0000 0000 0 000E 007B 0051
FFF9 FFEB 0000 0000 0000 0000 0000 0000 0 000E FFFB 0035
// Saturation at 4000 and the integral clamp at 8000
0640 07D0 F830 0640 F830 FC18 0000 FC18 0 0FA0 0FA0 F060
0640 07D0 F830 0640 F830 FC18 0000 FC18 0 0FA0 0FA0 F060
0640 07D0 F830 0640 F830 FC18 0000 FC18 0 0FA0 0FA0 F060
0000 0000 0000 0000 0000 0000 0000 0000 0 FDA8 F830 07D0
0000 0000 0000 0000 0000 0000 0000 0000 0 03E8 07D0 F830
F9C0 F830 07D0 F9C0 07D0 03E8 0000 03E8 0 F060 F060 0FA0
0000 0000 0000 0000 0000 0000 0000 0000 0 0898 0FA0 F060
// Second strobe while running is ignored
0050 0020 0010 0000 0000 0000 0000 0000 1 0302 0450 FC4C
0000 0000 0000 0000 0000 0000 0000 0000 0 023A 03D0 FC0C
0000 0000 0000 FFB0 0020 0000 0000 FFF0 1 01B8 0388 FBE8

/* dv/tb_body_frame_controller.sv */
/*
 * Testbench for the body frame rate controller
 * Replays vectors from the data file, checks the three rate
 * commands at each completion and reports one line per test
 */

`timescale 1ns/1ps
`default_nettype none

module tb_body_frame_controller;

	localparam int NUM_VECTORS = 20;
	localparam int VEC_WORDS = 12;
	localparam int F_IGNORE = 8;
	localparam int F_EXP_YAW = 9;
	localparam int F_EXP_ROLL = 10;
	localparam int F_EXP_PITCH = 11;
	localparam int HOLD_CYCLES = 3;
	localparam int TIMEOUT_CYCLES = 20 * NUM_VECTORS + 50;

	logic us_clk = 1'b0;
	logic resetn;
	logic start_signal;
	logic signed [15:0] yaw_target;
	logic signed [15:0] roll_target;
	logic signed [15:0] pitch_target;
	logic signed [15:0] yaw_rotation;
	logic signed [15:0] roll_rotation;
	logic signed [15:0] pitch_rotation;
	logic signed [15:0] roll_angle_error;
	logic signed [15:0] pitch_angle_error;
	logic signed [15:0] yaw_rate_out;
	logic signed [15:0] roll_rate_out;
	logic signed [15:0] pitch_rate_out;
	logic complete_signal;

	// Twelve words per vector, in the column order of the data file
	logic [15:0] vec_mem [0:NUM_VECTORS*VEC_WORDS-1];

	int cycle_count = 0;
	int check_errors = 0;
	int pass_count = 0;
	int fail_count = 0;

	body_frame_controller i_dut (
		.us_clk(us_clk),
		.resetn(resetn),
		.start_signal(start_signal),
		.yaw_target(yaw_target),
		.roll_target(roll_target),
		.pitch_target(pitch_target),
		.yaw_rotation(yaw_rotation),
		.roll_rotation(roll_rotation),
		.pitch_rotation(pitch_rotation),
		.roll_angle_error(roll_angle_error),
		.pitch_angle_error(pitch_angle_error),
		.yaw_rate_out(yaw_rate_out),
		.roll_rate_out(roll_rate_out),
		.pitch_rate_out(pitch_rate_out),
		.complete_signal(complete_signal)
	);

	always #50 us_clk = ~us_clk;

	// Watchdog over the whole run
	always @(posedge us_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the DUT never completed", cycle_count);
			$display("Regression failed");
			$finish;
		end
	end

	task automatic check_rate(input string test, input string name,
			input logic signed [15:0] got, input logic signed [15:0] expected);
		assert (got == expected) else begin
			$display("FAILED at %0d ns: %s %s is %0d, expected %0d",
				$time, test, name, got, expected);
			check_errors++;
		end
	endtask

	task automatic report_test(input string test, input int errors_before);
		if (check_errors == errors_before) begin
			pass_count++;
			$display("%s: PASS", test);
		end else begin
			fail_count++;
			$display("%s: FAIL", test);
		end
	endtask

	// Inverted operands mark a strobe that must not be latched
	task automatic drive_operands(input int vec, input logic invert);
		int base;
		base = vec * VEC_WORDS;
		yaw_target = vec_mem[base] ^ {16{invert}};
		roll_target = vec_mem[base + 1] ^ {16{invert}};
		pitch_target = vec_mem[base + 2] ^ {16{invert}};
		yaw_rotation = vec_mem[base + 3] ^ {16{invert}};
		roll_rotation = vec_mem[base + 4] ^ {16{invert}};
		pitch_rotation = vec_mem[base + 5] ^ {16{invert}};
		roll_angle_error = vec_mem[base + 6] ^ {16{invert}};
		pitch_angle_error = vec_mem[base + 7] ^ {16{invert}};
	endtask

	task automatic pulse_start(input int vec, input logic invert);
		@(posedge us_clk);
		#10;
		drive_operands(vec, invert);
		start_signal = 1'b1;
		@(posedge us_clk);
		#10;
		start_signal = 1'b0;
	endtask

	task automatic wait_for_complete;
		logic seen;
		seen = 1'b0;
		while (!seen) begin
			@(negedge us_clk);
			seen = complete_signal;
		end
	endtask

	task automatic check_reset_state;
		int errors_before;
		errors_before = check_errors;
		repeat (4) begin
			@(negedge us_clk);
			assert (!complete_signal) else begin
				$display("complete_signal rose at %0d ns before any start strobe", $time);
				check_errors++;
			end
			check_rate("reset", "yaw_rate_out", yaw_rate_out, 16'sd0);
			check_rate("reset", "roll_rate_out", roll_rate_out, 16'sd0);
			check_rate("reset", "pitch_rate_out", pitch_rate_out, 16'sd0);
		end
		report_test("reset", errors_before);
	endtask

	task automatic run_vector(input int vec);
		int base;
		int errors_before;
		int extra;
		logic ignore;
		logic signed [15:0] exp_yaw;
		logic signed [15:0] exp_roll;
		logic signed [15:0] exp_pitch;
		string test;
		base = vec * VEC_WORDS;
		errors_before = check_errors;
		extra = 0;
		ignore = vec_mem[base + F_IGNORE][0];
		exp_yaw = vec_mem[base + F_EXP_YAW];
		exp_roll = vec_mem[base + F_EXP_ROLL];
		exp_pitch = vec_mem[base + F_EXP_PITCH];
		test = $sformatf("vector %0d", vec + 1);
		pulse_start(vec, 1'b0);
		if (ignore) begin
			// Lands in the active state, after the PIDs have started
			pulse_start(vec, 1'b1);
		end
		wait_for_complete();
		check_rate(test, "yaw_rate_out", yaw_rate_out, exp_yaw);
		check_rate(test, "roll_rate_out", roll_rate_out, exp_roll);
		check_rate(test, "pitch_rate_out", pitch_rate_out, exp_pitch);
		// Outputs hold and no second completion follows
		repeat (HOLD_CYCLES) begin
			@(negedge us_clk);
			if (complete_signal)
				extra++;
			check_rate(test, "yaw_rate_out", yaw_rate_out, exp_yaw);
			check_rate(test, "roll_rate_out", roll_rate_out, exp_roll);
			check_rate(test, "pitch_rate_out", pitch_rate_out, exp_pitch);
		end
		assert (extra == 0) else begin
			$display("%s: complete_signal pulsed again after the cycle had ended", test);
			check_errors++;
		end
		report_test(test, errors_before);
	endtask

	initial begin
		int idle;
		resetn = 1'b0;
		start_signal = 1'b0;
		yaw_target = '0;
		roll_target = '0;
		pitch_target = '0;
		yaw_rotation = '0;
		roll_rotation = '0;
		pitch_rotation = '0;
		roll_angle_error = '0;
		pitch_angle_error = '0;
		void'($urandom(32));
		$readmemh("dv/rate_input.txt", vec_mem);
		repeat (3) @(posedge us_clk);
		#10;
		resetn = 1'b1;
		check_reset_state();
		for (int v = 0; v < NUM_VECTORS; v++) begin
			idle = $urandom_range(3, 0);
			repeat (idle) @(posedge us_clk);
			run_vector(v);
		end
		$display("Tests run: %0d, passed: %0d, failed: %0d",
			pass_count + fail_count, pass_count, fail_count);
		if (fail_count == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

/* hdl/axis_pid.sv */
/*
 * Single axis rate PID
 * Forms error, integral and difference, runs the three gain
 * products through the shared multiplier and clamps the sum
 */

`timescale 1ns/1ps
`default_nettype none

module axis_pid #(
	parameter flight_types_pkg::acc_t K_P = 1,
	parameter flight_types_pkg::acc_t K_I = 0,
	parameter flight_types_pkg::acc_t K_D = 0
) (
	input wire logic us_clk,
	input wire logic resetn,
	input wire logic start,
	input wire flight_types_pkg::rate_t setpoint,
	input wire flight_types_pkg::rate_t measurement,
	input wire logic mul_gnt,
	input wire logic mul_valid,
	input wire flight_types_pkg::acc_t mul_p,
	output logic mul_req,
	output flight_types_pkg::acc_t mul_a,
	output flight_types_pkg::acc_t mul_b,
	output flight_types_pkg::rate_t rate_out,
	output logic done
);
	import flight_types_pkg::*;
	import pid_gains_pkg::*;

	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_REQ = 2'd1;
	localparam logic [1:0] S_WAIT = 2'd2;
	localparam logic [1:0] S_CLAMP = 2'd3;

	logic [1:0] state;
	// 0 proportional, 1 integral, 2 derivative
	logic [1:0] op;

	// Carried from one control cycle to the next
	acc_t prev_err;
	acc_t integ;

	// Working copies for the running cycle
	acc_t err_w;
	acc_t integ_w;
	acc_t diff_w;
	acc_t sum;

	acc_t err_new;
	acc_t integ_sum;
	acc_t integ_new;
	acc_t sum_shift;
	rate_t rate_clamped;

	always_comb begin
		err_new = acc_t'(setpoint) - acc_t'(measurement);
		integ_sum = integ + err_new;
		if (integ_sum > INTEG_LIMIT)
			integ_new = INTEG_LIMIT;
		else if (integ_sum < -INTEG_LIMIT)
			integ_new = -INTEG_LIMIT;
		else
			integ_new = integ_sum;
	end

	// Gain and operand for the pending product
	always_comb begin
		case (op)
			2'd0: begin
				mul_a = K_P;
				mul_b = err_w;
			end
			2'd1: begin
				mul_a = K_I;
				mul_b = integ_w;
			end
			default: begin
				mul_a = K_D;
				mul_b = diff_w;
			end
		endcase
	end

	always_comb begin
		sum_shift = sum >>> FRAC_BITS;
		if (sum_shift > RATE_LIMIT)
			rate_clamped = rate_t'(RATE_LIMIT);
		else if (sum_shift < -RATE_LIMIT)
			rate_clamped = rate_t'(-RATE_LIMIT);
		else
			rate_clamped = rate_t'(sum_shift);
	end

	assign mul_req = (state == S_REQ);

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state <= S_IDLE;
			op <= 2'd0;
			done <= 1'b0;
			rate_out <= '0;
			prev_err <= '0;
			integ <= '0;
		end else begin
			done <= 1'b0;
			case (state)
				S_IDLE: begin
					if (start) begin
						op <= 2'd0;
						state <= S_REQ;
					end
				end
				S_REQ: begin
					if (mul_gnt)
						state <= S_WAIT;
				end
				S_WAIT: begin
					if (mul_valid) begin
						if (op == 2'd2) begin
							state <= S_CLAMP;
						end else begin
							op <= op + 2'd1;
							state <= S_REQ;
						end
					end
				end
				default: begin
					rate_out <= rate_clamped;
					prev_err <= err_w;
					integ <= integ_w;
					done <= 1'b1;
					state <= S_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge us_clk) begin
		if (state == S_IDLE && start) begin
			err_w <= err_new;
			integ_w <= integ_new;
			diff_w <= err_new - prev_err;
			sum <= '0;
		end else if (state == S_WAIT && mul_valid) begin
			sum <= sum + mul_p;
		end
	end

	// The top level must not restart an axis in its done cycle
	a_no_req_on_done: assert property (@(posedge us_clk) disable iff (!resetn)
		done |=> !mul_req);

endmodule

`default_nettype wire

/* hdl/body_frame_controller.sv */
/*
 * Body frame rate controller
 * Latches targets, IMU rates and angle errors on a start strobe,
 * runs the yaw, roll and pitch PIDs and pulses complete
 */

`timescale 1ns/1ps
`default_nettype none

module body_frame_controller (
	input wire logic us_clk,
	input wire logic resetn,
	input wire logic start_signal,
	input wire flight_types_pkg::rate_t yaw_target,
	input wire flight_types_pkg::rate_t roll_target,
	input wire flight_types_pkg::rate_t pitch_target,
	input wire flight_types_pkg::rate_t yaw_rotation,
	input wire flight_types_pkg::rate_t roll_rotation,
	input wire flight_types_pkg::rate_t pitch_rotation,
	input wire flight_types_pkg::rate_t roll_angle_error,
	input wire flight_types_pkg::rate_t pitch_angle_error,
	output flight_types_pkg::rate_t yaw_rate_out,
	output flight_types_pkg::rate_t roll_rate_out,
	output flight_types_pkg::rate_t pitch_rate_out,
	output logic complete_signal
);
	import flight_types_pkg::*;
	import pid_gains_pkg::*;

	// One-hot cycle states
	localparam logic [3:0] ST_WAITING = 4'b0001;
	localparam logic [3:0] ST_STARTING = 4'b0010;
	localparam logic [3:0] ST_ACTIVE = 4'b0100;
	localparam logic [3:0] ST_COMPLETE = 4'b1000;

	logic [3:0] state;
	logic [3:0] state_next;
	logic accept;
	logic pid_start;
	logic all_done;
	logic [NUM_AXES-1:0] done_flags;
	wire logic [NUM_AXES-1:0] pid_done;
	wire logic [NUM_AXES-1:0] mul_req;
	logic [NUM_AXES-1:0] mul_gnt;
	logic [NUM_AXES-1:0] mul_valid;
	acc_t mul_p;
	acc_t yaw_a, yaw_b, roll_a, roll_b, pitch_a, pitch_b;

	// Sign-corrected operands for the PIDs
	rate_t yaw_sp, roll_sp, pitch_sp;
	rate_t yaw_meas, roll_meas, pitch_meas;

	// Strobes during a running cycle are dropped
	assign accept = start_signal && (state == ST_WAITING);
	assign pid_start = (state == ST_STARTING);
	assign complete_signal = (state == ST_COMPLETE);
	assign all_done = &(done_flags | pid_done);

	// Yaw and pitch gyro axes point against the body frame
	always_ff @(posedge us_clk) begin
		if (accept) begin
			yaw_sp <= yaw_target;
			roll_sp <= roll_target + roll_angle_error;
			pitch_sp <= pitch_target + pitch_angle_error;
			yaw_meas <= -yaw_rotation;
			roll_meas <= roll_rotation;
			pitch_meas <= -pitch_rotation;
		end
	end

	always_comb begin
		case (state)
			ST_WAITING:
				state_next = accept ? ST_STARTING : ST_WAITING;
			ST_STARTING:
				state_next = ST_ACTIVE;
			ST_ACTIVE:
				state_next = all_done ? ST_COMPLETE : ST_ACTIVE;
			default:
				state_next = ST_WAITING;
		endcase
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state <= ST_WAITING;
			done_flags <= '0;
		end else begin
			state <= state_next;
			if (pid_start)
				done_flags <= '0;
			else
				done_flags <= done_flags | pid_done;
		end
	end

	axis_pid #(.K_P(YAW_K_P), .K_I(YAW_K_I), .K_D(YAW_K_D)) yaw_pid (
		.us_clk(us_clk),
		.resetn(resetn),
		.start(pid_start),
		.setpoint(yaw_sp),
		.measurement(yaw_meas),
		.mul_gnt(mul_gnt[AXIS_YAW]),
		.mul_valid(mul_valid[AXIS_YAW]),
		.mul_p(mul_p),
		.mul_req(mul_req[AXIS_YAW]),
		.mul_a(yaw_a),
		.mul_b(yaw_b),
		.rate_out(yaw_rate_out),
		.done(pid_done[AXIS_YAW])
	);

	axis_pid #(.K_P(ROLL_K_P), .K_I(ROLL_K_I), .K_D(ROLL_K_D)) roll_pid (
		.us_clk(us_clk),
		.resetn(resetn),
		.start(pid_start),
		.setpoint(roll_sp),
		.measurement(roll_meas),
		.mul_gnt(mul_gnt[AXIS_ROLL]),
		.mul_valid(mul_valid[AXIS_ROLL]),
		.mul_p(mul_p),
		.mul_req(mul_req[AXIS_ROLL]),
		.mul_a(roll_a),
		.mul_b(roll_b),
		.rate_out(roll_rate_out),
		.done(pid_done[AXIS_ROLL])
	);

	axis_pid #(.K_P(PITCH_K_P), .K_I(PITCH_K_I), .K_D(PITCH_K_D)) pitch_pid (
		.us_clk(us_clk),
		.resetn(resetn),
		.start(pid_start),
		.setpoint(pitch_sp),
		.measurement(pitch_meas),
		.mul_gnt(mul_gnt[AXIS_PITCH]),
		.mul_valid(mul_valid[AXIS_PITCH]),
		.mul_p(mul_p),
		.mul_req(mul_req[AXIS_PITCH]),
		.mul_a(pitch_a),
		.mul_b(pitch_b),
		.rate_out(pitch_rate_out),
		.done(pid_done[AXIS_PITCH])
	);

	mult_arbiter i_mult_arbiter (
		.us_clk(us_clk),
		.resetn(resetn),
		.req(mul_req),
		.a_yaw(yaw_a),
		.b_yaw(yaw_b),
		.a_roll(roll_a),
		.b_roll(roll_b),
		.a_pitch(pitch_a),
		.b_pitch(pitch_b),
		.gnt(mul_gnt),
		.p_valid(mul_valid),
		.p(mul_p)
	);

	a_complete_pulse: assert property (@(posedge us_clk) disable iff (!resetn)
		complete_signal |=> !complete_signal);

	// PIDs only start right after an accepted strobe
	a_start_after_accept: assert property (@(posedge us_clk) disable iff (!resetn)
		pid_start |-> $past(accept));

endmodule

`default_nettype wire

/* hdl/flight_types_pkg.sv */
/*
 * Flight controller number formats
 * Signed 12.4 fixed point for rates, 32-bit products and sums,
 * and the requester order at the shared multiplier
 */

`default_nettype none

package flight_types_pkg;

	// Word widths
	localparam int RATE_W = 16;
	localparam int ACC_W = 32;

	// Fraction bits of the 12.4 format
	localparam int FRAC_BITS = 4;

	// Rates, errors and rate commands
	typedef logic signed [RATE_W-1:0] rate_t;

	// Products, sums and the integral
	typedef logic signed [ACC_W-1:0] acc_t;

	// Requesters at the multiplier arbiter
	localparam int NUM_AXES = 3;
	localparam int AXIS_YAW = 0;
	localparam int AXIS_ROLL = 1;
	localparam int AXIS_PITCH = 2;

	// Width of a requester index
	localparam int AXIS_IDX_W = $clog2(NUM_AXES);

endpackage

`default_nettype wire

/* hdl/mult_arbiter.sv */
/*
 * Shared multiplier arbiter
 * Round-robin grant among the axis PIDs, one signed multiply
 * per cycle, product registered and tagged with its requester
 */

`timescale 1ns/1ps
`default_nettype none

module mult_arbiter (
	input wire logic us_clk,
	input wire logic resetn,
	input wire logic [flight_types_pkg::NUM_AXES-1:0] req,
	input wire flight_types_pkg::acc_t a_yaw,
	input wire flight_types_pkg::acc_t b_yaw,
	input wire flight_types_pkg::acc_t a_roll,
	input wire flight_types_pkg::acc_t b_roll,
	input wire flight_types_pkg::acc_t a_pitch,
	input wire flight_types_pkg::acc_t b_pitch,
	output logic [flight_types_pkg::NUM_AXES-1:0] gnt,
	output logic [flight_types_pkg::NUM_AXES-1:0] p_valid,
	output flight_types_pkg::acc_t p
);
	import flight_types_pkg::*;

	logic [AXIS_IDX_W-1:0] ptr;
	logic [AXIS_IDX_W-1:0] ptr_next;
	acc_t a_in [NUM_AXES];
	acc_t b_in [NUM_AXES];
	acc_t a_sel;
	acc_t b_sel;

	assign a_in[AXIS_YAW] = a_yaw;
	assign b_in[AXIS_YAW] = b_yaw;
	assign a_in[AXIS_ROLL] = a_roll;
	assign b_in[AXIS_ROLL] = b_roll;
	assign a_in[AXIS_PITCH] = a_pitch;
	assign b_in[AXIS_PITCH] = b_pitch;

	// Search starts at the pointer and wraps around
	always_comb begin
		int idx;
		logic found;
		gnt = '0;
		found = 1'b0;
		ptr_next = ptr;
		a_sel = '0;
		b_sel = '0;
		for (int k = 0; k < NUM_AXES; k++) begin
			idx = int'(ptr) + k;
			if (idx >= NUM_AXES)
				idx = idx - NUM_AXES;
			if (!found && req[idx]) begin
				found = 1'b1;
				gnt[idx] = 1'b1;
				a_sel = a_in[idx];
				b_sel = b_in[idx];
				ptr_next = (idx == NUM_AXES - 1) ? '0 : AXIS_IDX_W'(idx + 1);
			end
		end
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			ptr <= '0;
			p_valid <= '0;
		end else begin
			ptr <= ptr_next;
			p_valid <= gnt;
		end
	end

	// Low 32 bits of the product
	always_ff @(posedge us_clk) begin
		if (|gnt)
			p <= a_sel * b_sel;
	end

	a_gnt_onehot: assert property (@(posedge us_clk) disable iff (!resetn)
		$onehot0(gnt));

endmodule

`default_nettype wire

/* hdl/pid_gains_pkg.sv */
/*
 * Rate loop tuning
 * Per-axis PID gains and the rate and integral limits,
 * gains scaled by 2^FRAC_BITS so 16 means a gain of one
 */

`default_nettype none

package pid_gains_pkg;

	// Yaw reacts softly
	localparam flight_types_pkg::acc_t YAW_K_P = 24;
	localparam flight_types_pkg::acc_t YAW_K_I = 2;
	localparam flight_types_pkg::acc_t YAW_K_D = 8;

	// Roll and pitch share a tune on a symmetric frame
	localparam flight_types_pkg::acc_t ROLL_K_P = 32;
	localparam flight_types_pkg::acc_t ROLL_K_I = 4;
	localparam flight_types_pkg::acc_t ROLL_K_D = 16;

	localparam flight_types_pkg::acc_t PITCH_K_P = 32;
	localparam flight_types_pkg::acc_t PITCH_K_I = 4;
	localparam flight_types_pkg::acc_t PITCH_K_D = 16;

	// 250 deg/s in 12.4
	localparam flight_types_pkg::acc_t RATE_LIMIT = 250 << flight_types_pkg::FRAC_BITS;

	// Anti-windup bound on the summed error
	localparam flight_types_pkg::acc_t INTEG_LIMIT = 8000;

endpackage

`default_nettype wire

/* sim.f */
hdl/flight_types_pkg.sv
hdl/pid_gains_pkg.sv
hdl/mult_arbiter.sv
hdl/axis_pid.sv
hdl/body_frame_controller.sv
dv/tb_body_frame_controller.sv
